//--- tb.f
hw/coef_mem_pkg.sv
hw/hs_pkg.sv
hw/bank_if.sv
hw/coef_ram_bank.sv
hw/coef_wr_dispatch.sv
hw/coef_rd_collect.sv
hw/coef_bank_store.sv
dv/tb_clk_gen.sv
dv/tb_coef_store.sv

//--- run.sh
#!/bin/sh
# build and run the coefficient store testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_coef_store -f tb.f -o sim_coef_store \
    || { echo "verilator build failed"; exit 1; }

./obj_dir/sim_coef_store > sim.log 2>&1 \
    || { cat sim.log; echo "simulation exited with an error"; exit 1; }

cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1 || exit 0

//--- dv/tb_coef_store.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the coefficient store with LFSR stimulus on both four-phase
// ports, checked against a reference memory model and guarded by a watchdog
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_coef_store;

    localparam int CLK_PERIOD = 8;
    localparam int ADDR_SPACE = coef_mem_pkg::N_BANKS * coef_mem_pkg::BANK_DEPTH;
    localparam int N_RAND_WR  = 200;
    localparam int HOLD_LEN   = 6;
    localparam int ACK_BOUND  = 16;
    // edges are counted from the edge that drives req and the DUT samples req on the next one
    // write ack follows the sampling edge by one edge and read ack by two
    localparam int WR_ACK_EDGES   = 2;
    localparam int RD_ACK_EDGES   = 3;
    localparam int ACK_DROP_EDGES = 1;
    // random writes, their readback, the sweep twice and the directed extras
    localparam int OP_COUNT = N_RAND_WR + ADDR_SPACE + 2 * ADDR_SPACE + 16;
    localparam int TIMEOUT  = OP_COUNT * 16 * CLK_PERIOD + 100 * CLK_PERIOD;

    logic                clk;
    logic                rst_n;
    logic                wr_req;
    coef_mem_pkg::addr_t wr_addr;
    coef_mem_pkg::coef_t wr_data;
    logic                wr_ack;
    logic                rd_req;
    coef_mem_pkg::addr_t rd_addr;
    logic                rd_ack;
    coef_mem_pkg::coef_t rd_data;

    // reference model of the whole address space
    coef_mem_pkg::coef_t model_mem [ADDR_SPACE];
    logic                written   [ADDR_SPACE];

    logic [15:0] lfsr_q = 16'd60;
    int          mismatch_errs = 0;
    int          other_errs = 0;

    tb_clk_gen u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    coef_bank_store DUT (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .wr_req_i  (wr_req),
        .wr_addr_i (wr_addr),
        .wr_data_i (wr_data),
        .wr_ack_o  (wr_ack),
        .rd_req_i  (rd_req),
        .rd_addr_i (rd_addr),
        .rd_ack_o  (rd_ack),
        .rd_data_o (rd_data)
    );

    // galois form of x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    // one LFSR step per bit and the new low bit is shifted in
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // every address bit shows up in the word, so any aliasing between rows or banks is visible
    function automatic coef_mem_pkg::coef_t sweep_word(input coef_mem_pkg::addr_t a);
        return coef_mem_pkg::coef_t'({a, ~a, a ^ 8'h5a});
    endfunction

    task automatic check_idle_outputs(input string phase);
        assert (wr_ack === 1'b0 && rd_ack === 1'b0 && rd_data === '0) else begin
            mismatch_errs++;
            $display("mismatch at %0t: %s, wr_ack %b rd_ack %b rd_data %h, all expected zero",
                     $time, phase, wr_ack, rd_ack, rd_data);
        end
    endtask

    // full four-phase write where req is held for hold extra cycles once ack is seen
    task automatic write_txn(input coef_mem_pkg::addr_t a, input coef_mem_pkg::coef_t d,
                             input int hold);
        int m;
        @(posedge clk);
        wr_req  <= 1'b1;
        wr_addr <= a;
        wr_data <= d;
        m = 0;
        do begin
            @(negedge clk);
            m++;
        end while (!wr_ack && m < ACK_BOUND);
        assert (wr_ack === 1'b1) else begin
            other_errs++;
            $display("handshake timeout: write ack never rose for address %h", a);
        end
        if (wr_ack === 1'b1) begin
            assert (m - 1 == WR_ACK_EDGES) else begin
                mismatch_errs++;
                $display("mismatch at %0t: write ack rose %0d edges after req, expected %0d",
                         $time, m - 1, WR_ACK_EDGES);
            end
        end
        repeat (hold) begin
            @(negedge clk);
            assert (wr_ack === 1'b1) else begin
                mismatch_errs++;
                $display("mismatch at %0t: write ack dropped while req held", $time);
            end
        end
        @(posedge clk);
        wr_req <= 1'b0;
        m = 0;
        do begin
            @(negedge clk);
            m++;
        end while (wr_ack && m < ACK_BOUND);
        assert (wr_ack === 1'b0) else begin
            other_errs++;
            $display("handshake timeout: write ack stayed high after req dropped");
        end
        if (wr_ack === 1'b0) begin
            assert (m - 1 == ACK_DROP_EDGES) else begin
                mismatch_errs++;
                $display("mismatch at %0t: write ack fell %0d edges after req, expected %0d",
                         $time, m - 1, ACK_DROP_EDGES);
            end
        end
    endtask

    // full four-phase read where the returned word must match exp and stay put while req is held
    task automatic read_txn(input coef_mem_pkg::addr_t a, input coef_mem_pkg::coef_t exp,
                            input int hold);
        int                  m;
        coef_mem_pkg::coef_t first;
        @(posedge clk);
        rd_req  <= 1'b1;
        rd_addr <= a;
        m = 0;
        do begin
            @(negedge clk);
            m++;
        end while (!rd_ack && m < ACK_BOUND);
        first = rd_data;
        assert (rd_ack === 1'b1) else begin
            other_errs++;
            $display("handshake timeout: read ack never rose for address %h", a);
        end
        if (rd_ack === 1'b1) begin
            assert (m - 1 == RD_ACK_EDGES) else begin
                mismatch_errs++;
                $display("mismatch at %0t: read ack rose %0d edges after req, expected %0d",
                         $time, m - 1, RD_ACK_EDGES);
            end
            assert (first === exp) else begin
                mismatch_errs++;
                $display("mismatch at %0t: read of %h expected %h got %h",
                         $time, a, exp, first);
            end
        end
        repeat (hold) begin
            @(negedge clk);
            assert (rd_ack === 1'b1 && rd_data === first) else begin
                mismatch_errs++;
                $display("mismatch at %0t: read ack %b data %h while req held, expected 1 %h",
                         $time, rd_ack, rd_data, first);
            end
        end
        @(posedge clk);
        rd_req <= 1'b0;
        m = 0;
        do begin
            @(negedge clk);
            m++;
        end while (rd_ack && m < ACK_BOUND);
        assert (rd_ack === 1'b0) else begin
            other_errs++;
            $display("handshake timeout: read ack stayed high after req dropped");
        end
        if (rd_ack === 1'b0) begin
            assert (m - 1 == ACK_DROP_EDGES) else begin
                mismatch_errs++;
                $display("mismatch at %0t: read ack fell %0d edges after req, expected %0d",
                         $time, m - 1, ACK_DROP_EDGES);
            end
        end
    endtask

    // watchdog that ends a stuck run after a time sized from the operation count plus a margin
    initial begin
        #(TIMEOUT);
        $display("watchdog expired after %0d time units, the run did not complete", TIMEOUT);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        coef_mem_pkg::addr_t a;
        coef_mem_pkg::coef_t d;
        coef_mem_pkg::coef_t old;
        wr_req  = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        rd_req  = 1'b0;
        rd_addr = '0;
        for (int i = 0; i < ADDR_SPACE; i++) begin
            a = coef_mem_pkg::addr_t'(i);
            written[a] = 1'b0;
        end

        // the first negedge already follows one reset edge
        @(negedge clk);
        while (!rst_n) begin
            check_idle_outputs("during reset");
            @(negedge clk);
        end
        repeat (2) begin
            check_idle_outputs("right after reset");
            @(negedge clk);
        end

        // random writes where repeated addresses rewrite older entries on the way
        for (int i = 0; i < N_RAND_WR; i++) begin
            a = coef_mem_pkg::addr_t'(rand_bits(coef_mem_pkg::ADDR_W));
            d = coef_mem_pkg::coef_t'(rand_bits(coef_mem_pkg::COEF_W));
            write_txn(a, d, 0);
            model_mem[a] = d;
            written[a]   = 1'b1;
        end

        // two more writes to the last address and only the newest may come back
        repeat (2) begin
            d = coef_mem_pkg::coef_t'(rand_bits(coef_mem_pkg::COEF_W));
            write_txn(a, d, 0);
            model_mem[a] = d;
        end
        read_txn(a, model_mem[a], 0);

        for (int i = 0; i < ADDR_SPACE; i++) begin
            a = coef_mem_pkg::addr_t'(i);
            if (written[a]) begin
                read_txn(a, model_mem[a], 0);
            end
        end

        // directed sweep over every bank and row
        for (int i = 0; i < ADDR_SPACE; i++) begin
            a = coef_mem_pkg::addr_t'(i);
            write_txn(a, sweep_word(a), 0);
            model_mem[a] = sweep_word(a);
            written[a]   = 1'b1;
        end
        for (int i = ADDR_SPACE - 1; i >= 0; i--) begin
            a = coef_mem_pkg::addr_t'(i);
            read_txn(a, model_mem[a], 0);
        end

        // a write and a read of one address raised together where the read sees the old word
        for (int b = 0; b < coef_mem_pkg::N_BANKS; b++) begin
            a = coef_mem_pkg::addr_t'(rand_bits(coef_mem_pkg::ROW_W) << coef_mem_pkg::BANK_W);
            a = a | coef_mem_pkg::addr_t'(b);
            old = model_mem[a];
            d = ~old;
            fork
                write_txn(a, d, 0);
                read_txn(a, old, 0);
            join
            model_mem[a] = d;
            read_txn(a, d, 0);
        end

        // back-pressure on both ports
        d = coef_mem_pkg::coef_t'(rand_bits(coef_mem_pkg::COEF_W));
        write_txn(a, d, HOLD_LEN);
        model_mem[a] = d;
        read_txn(a, model_mem[a], HOLD_LEN);

        $display("errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
        if (mismatch_errs + other_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- dv/tb_clk_gen.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock and synchronous reset source
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    localparam int HALF_PERIOD  = 4;
    localparam int RESET_CYCLES = 8;

    // free running clock, period of two half periods
    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // reset is released on a rising edge so the DUT sees it low for exactly RESET_CYCLES edges
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

//--- hw/coef_bank_store.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// coefficient store top: four interleaved 1r1w banks behind independent
// four-phase write and read host ports
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module coef_bank_store (
    input  logic                clk_i,
    input  logic                rst_n_i,

    // host write port
    input  logic                wr_req_i,
    input  coef_mem_pkg::addr_t wr_addr_i,
    input  coef_mem_pkg::coef_t wr_data_i,
    output logic                wr_ack_o,

    // host read port
    input  logic                rd_req_i,
    input  coef_mem_pkg::addr_t rd_addr_i,
    output logic                rd_ack_o,
    output coef_mem_pkg::coef_t rd_data_o
);

    // one bundle per bank, shared by dispatcher, collector and the bank
    bank_if bank_bus [coef_mem_pkg::N_BANKS] ();

    // write side
    // the dispatcher only touches the write half of each bundle, so it never
    // holds up the read port
    coef_wr_dispatch u_wr_dispatch (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .wr_req_i  (wr_req_i),
        .wr_addr_i (wr_addr_i),
        .wr_data_i (wr_data_i),
        .wr_ack_o  (wr_ack_o),
        .banks     (bank_bus)
    );

    // read side
    // relies on idle banks returning zero when it merges their outputs
    coef_rd_collect u_rd_collect (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .rd_req_i  (rd_req_i),
        .rd_addr_i (rd_addr_i),
        .rd_ack_o  (rd_ack_o),
        .rd_data_o (rd_data_o),
        .banks     (bank_bus)
    );

    // the banks themselves
    // bank b holds every host address whose low bits equal b
    for (genvar b = 0; b < coef_mem_pkg::N_BANKS; b++) begin : g_bank
        coef_ram_bank u_bank (
            .clk_i (clk_i),
            .bank  (bank_bus[b])
        );
    end

endmodule

//--- hw/coef_rd_collect.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// read port FSM: enables one bank read, merges the registered bank
// outputs and holds the word through the four-phase handshake
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module coef_rd_collect (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                rd_req_i,
    input  coef_mem_pkg::addr_t rd_addr_i,
    output logic                rd_ack_o,
    output coef_mem_pkg::coef_t rd_data_o,
    bank_if.rd_mp               banks [coef_mem_pkg::N_BANKS]
);

    hs_pkg::rd_state_t                state_q;
    logic [coef_mem_pkg::N_BANKS-1:0] re_q;
    logic [coef_mem_pkg::N_BANKS-1:0] bank_onehot;
    coef_mem_pkg::row_t               raddr_q;
    coef_mem_pkg::bank_sel_t          sel_bank;
    coef_mem_pkg::row_t               sel_row;
    coef_mem_pkg::coef_t              bank_rdata [coef_mem_pkg::N_BANKS];
    coef_mem_pkg::coef_t              merged;
    logic                             accept;

    // split the host address into bank and row
    assign sel_bank = rd_addr_i[coef_mem_pkg::BANK_W-1:0];
    assign sel_row  = rd_addr_i[coef_mem_pkg::ADDR_W-1:coef_mem_pkg::BANK_W];

    // requests are only taken from idle
    assign accept = (state_q == hs_pkg::RD_IDLE) && rd_req_i;

    // read enable pattern, a single bank per request
    assign bank_onehot = coef_mem_pkg::N_BANKS'(1) << sel_bank;

    // gather the bank outputs into a plain array so they can be looped over
    for (genvar b = 0; b < coef_mem_pkg::N_BANKS; b++) begin : g_rd_bank
        assign banks[b].re    = re_q[b];
        assign banks[b].raddr = raddr_q;
        assign bank_rdata[b]  = banks[b].rdata;
    end

    // every bank that was not enabled returns zero, so the OR of all of
    // them is exactly the addressed word
    always_comb begin
        merged = '0;
        for (int b = 0; b < coef_mem_pkg::N_BANKS; b++) begin
            merged = merged | bank_rdata[b];
        end
    end

    // control path and the held read word
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q   <= hs_pkg::RD_IDLE;
            re_q      <= '0;
            rd_ack_o  <= 1'b0;
            rd_data_o <= '0;
        end else begin
            // the enable lasts one cycle, the bank output follows one edge later
            re_q <= accept ? bank_onehot : '0;
            case (state_q)
                hs_pkg::RD_IDLE: begin
                    if (rd_req_i) begin
                        state_q <= hs_pkg::RD_ISSUE;
                    end
                end
                hs_pkg::RD_ISSUE: begin
                    // the addressed bank registers its word on this edge
                    state_q <= hs_pkg::RD_CAPTURE;
                end
                hs_pkg::RD_CAPTURE: begin
                    rd_data_o <= merged;
                    rd_ack_o  <= 1'b1;
                    state_q   <= hs_pkg::RD_HOLD;
                end
                hs_pkg::RD_HOLD: begin
                    // rd_data_o keeps the captured word while the host holds req
                    if (!rd_req_i) begin
                        rd_ack_o <= 1'b0;
                        state_q  <= hs_pkg::RD_IDLE;
                    end
                end
                default: begin
                    state_q <= hs_pkg::RD_IDLE;
                end
            endcase
        end
    end

    // row of the pending read, loaded once per accepted request
    always_ff @(posedge clk_i) begin
        if (accept) begin
            raddr_q <= sel_row;
        end
    end

endmodule

//--- hw/coef_wr_dispatch.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// write port FSM: samples a four-phase request, decodes the bank and
// pulses one bank write strobe, then acknowledges the host
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module coef_wr_dispatch (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                wr_req_i,
    input  coef_mem_pkg::addr_t wr_addr_i,
    input  coef_mem_pkg::coef_t wr_data_i,
    output logic                wr_ack_o,
    bank_if.wr_mp               banks [coef_mem_pkg::N_BANKS]
);

    hs_pkg::wr_state_t                state_q;
    logic [coef_mem_pkg::N_BANKS-1:0] we_q;
    logic [coef_mem_pkg::N_BANKS-1:0] bank_onehot;
    coef_mem_pkg::row_t               row_q;
    coef_mem_pkg::coef_t              data_q;
    coef_mem_pkg::bank_sel_t          sel_bank;
    coef_mem_pkg::row_t               sel_row;
    logic                             accept;

    // split the host address into bank and row
    assign sel_bank = wr_addr_i[coef_mem_pkg::BANK_W-1:0];
    assign sel_row  = wr_addr_i[coef_mem_pkg::ADDR_W-1:coef_mem_pkg::BANK_W];

    // a request is taken only from idle, so a held req is never taken twice
    assign accept = (state_q == hs_pkg::WR_IDLE) && wr_req_i;

    // one-hot strobe pattern for the addressed bank
    assign bank_onehot = coef_mem_pkg::N_BANKS'(1) << sel_bank;

    // control path of the handshake
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q  <= hs_pkg::WR_IDLE;
            we_q     <= '0;
            wr_ack_o <= 1'b0;
        end else begin
            // strobes live for exactly one cycle unless a new accept sets them
            we_q <= accept ? bank_onehot : '0;
            case (state_q)
                hs_pkg::WR_IDLE: begin
                    if (wr_req_i) begin
                        state_q <= hs_pkg::WR_COMMIT;
                    end
                end
                hs_pkg::WR_COMMIT: begin
                    // the bank stores the word on this edge, ack goes up with it
                    wr_ack_o <= 1'b1;
                    state_q  <= hs_pkg::WR_HOLD;
                end
                hs_pkg::WR_HOLD: begin
                    // host holding req is the back-pressure, wait it out
                    if (!wr_req_i) begin
                        wr_ack_o <= 1'b0;
                        state_q  <= hs_pkg::WR_IDLE;
                    end
                end
                default: begin
                    state_q <= hs_pkg::WR_IDLE;
                end
            endcase
        end
    end

    // payload, captured once per accepted request
    always_ff @(posedge clk_i) begin
        if (accept) begin
            row_q  <= sel_row;
            data_q <= wr_data_i;
        end
    end

    // row and word go to every bank, only the strobe is per bank
    for (genvar b = 0; b < coef_mem_pkg::N_BANKS; b++) begin : g_wr_bank
        assign banks[b].we    = we_q[b];
        assign banks[b].waddr = row_q;
        assign banks[b].wdata = data_q;
    end

endmodule

//--- hw/coef_ram_bank.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one 64-entry 1r1w coefficient RAM with a registered read port that
// returns zero whenever no read is requested
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module coef_ram_bank (
    input  logic  clk_i,
    bank_if.ram_mp bank
);

    // storage array, contents are undefined until first written
    coef_mem_pkg::coef_t mem [coef_mem_pkg::BANK_DEPTH];

    // write port
    // a strobe stores the word at the end of its cycle
    always_ff @(posedge clk_i) begin
        if (bank.we) begin
            mem[bank.waddr] <= bank.wdata;
        end
    end

    // read port
    // the array is read before the write on the same edge lands, so a read
    // and a write of the same row in one cycle return the old word
    always_ff @(posedge clk_i) begin
        if (bank.re) begin
            bank.rdata <= mem[bank.raddr];
        end else begin
            // idle banks drive zero so that the collector can OR all banks
            // together without a select mux
            bank.rdata <= '0;
        end
    end

endmodule

//--- hw/bank_if.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// signals of one coefficient bank: write side, read side and read data
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
interface bank_if;

    // write side, a one-cycle strobe with row and word
    logic                we;
    coef_mem_pkg::row_t  waddr;
    coef_mem_pkg::coef_t wdata;

    // read side, a one-cycle enable with row
    logic                re;
    coef_mem_pkg::row_t  raddr;

    // registered bank output, zero on any cycle after an idle read port
    coef_mem_pkg::coef_t rdata;

    // the write dispatcher only drives the write side
    modport wr_mp (
        output we,
        output waddr,
        output wdata
    );

    // the read collector drives the read side and merges rdata
    modport rd_mp (
        output re,
        output raddr,
        input  rdata
    );

    // the bank itself consumes both sides and returns rdata
    modport ram_mp (
        input  we,
        input  waddr,
        input  wdata,
        input  re,
        input  raddr,
        output rdata
    );

endinterface

//--- hw/hs_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// state encodings of the four-phase req/ack port FSMs
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package hs_pkg;

    // write port FSM
    // idle waits for req, commit is the cycle the bank stores the word,
    // hold keeps ack high until the host drops req
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_COMMIT,
        WR_HOLD
    } wr_state_t;

    // read port FSM
    // issue is the cycle the bank registers its output, capture merges the
    // bank outputs into the host register, hold waits for req to drop
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ISSUE,
        RD_CAPTURE,
        RD_HOLD
    } rd_state_t;

endpackage

//--- hw/coef_mem_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// coefficient store geometry with the bank count, bank depth and the
// derived widths and types shared by the host ports and the RAM banks
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package coef_mem_pkg;

    // four interleaved banks that the low address bits select
    localparam int N_BANKS = 4;

    // entries held by each bank
    localparam int BANK_DEPTH = 64;

    // a 23-bit modulus residue fits with one bit to spare
    localparam int COEF_W = 24;

    // widths of the bank number, the row index and the whole host address
    localparam int BANK_W = $clog2(N_BANKS);
    localparam int ROW_W  = $clog2(BANK_DEPTH);
    localparam int ADDR_W = BANK_W + ROW_W;

    // one polynomial coefficient
    typedef logic [COEF_W-1:0] coef_t;

    // row index inside a single bank
    typedef logic [ROW_W-1:0] row_t;

    // bank number as taken from the low bits of a host address
    typedef logic [BANK_W-1:0] bank_sel_t;

    // host address as seen on both ports
    // bits [BANK_W-1:0] pick the bank and the bits above them pick the row
    typedef logic [ADDR_W-1:0] addr_t;

endpackage
